// File: verilog/eth_rmii_params.svh
// Frame constants; buffers assume frames of at most 256 bytes including the FCS
`ifndef ETH_RMII_PARAMS_SVH
`define ETH_RMII_PARAMS_SVH

// Buffer address width, one byte per location
`define BUF_AW 8

// Payload is padded with zeros up to this many bytes
`define MIN_PAYLOAD 60

// Inter-frame gap in clk_rmii cycles
`define IFG_CYCLES 48

// CRC-32 start value
`define CRC_INIT 32'hFFFF_FFFF

// Remainder of a good frame, normal bit order
`define CRC_RESIDUE 32'hC704_DD7B

// MAC address after reset, first byte on the wire in bits 47:40
`define MAC_RESET 48'h02_00_00_00_00_01

`endif

// File: verilog/eth_rmii_pkg.sv
// Shared types; byte beats are sized by BUF_AW, so the params header must be on the include path
`default_nettype none
`include "eth_rmii_params.svh"

package eth_rmii_pkg;

   typedef struct packed {
      logic        sel;
      logic        we;
      logic [11:0] addr;           // Word address
      logic [31:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic               wr;
      logic [`BUF_AW-1:0] addr;
      logic [7:0]         data;
   } byte_beat_t;

   typedef enum logic [1:0] {
      REG_MAC_LO,
      REG_MAC_HI,
      REG_TX_LEN,
      REG_RX_STAT
   } reg_addr_e;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PRE,
      TX_DATA,
      TX_PAD,
      TX_FCS,
      TX_GAP
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_PRE,
      RX_DATA,
      RX_DROP,
      RX_DONE
   } rx_state_e;

   typedef struct packed {
      logic       valid;
      logic       fcs_bad;
      logic [8:0] len;             // Includes the FCS
   } rx_status_t;

endpackage

`default_nettype wire

// File: verilog/eth_crc32.sv
// Reflected CRC-32 register, one byte per enabled cycle; o_crc is the raw register, not inverted
`timescale 1ns/1ns
`default_nettype none
`include "eth_rmii_params.svh"

module eth_crc32
(
   input  wire         clk_rmii,
   input  wire         rstn,
   input  wire         i_init,
   input  wire         i_en,
   input  wire  [7:0]  i_data,
   output logic [31:0] o_crc
);

   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         c = (c >> 1) ^ ((c[0] ^ data[i]) ? 32'hEDB8_8320 : 32'h0);   // Reflected 04C11DB7
      end
      return c;
   endfunction

   always_ff @(posedge clk_rmii)
   begin
      if (!rstn || i_init)
         o_crc <= `CRC_INIT;
      else if (i_en)
         o_crc <= crc_byte(o_crc, i_data);
   end

endmodule

`default_nettype wire

// File: verilog/eth_frame_buf.sv
// Byte memory with one-cycle reads on both ports; a MAC write wins over a CPU write to one address
`timescale 1ns/1ns
`default_nettype none
`include "eth_rmii_params.svh"

module eth_frame_buf
#(
   parameter int AW = `BUF_AW
)
(
   input  wire                          clk_rmii,
   input  wire eth_rmii_pkg::byte_beat_t i_mac_wr,
   input  wire  [AW-1:0]                i_mac_raddr,
   output logic [7:0]                   o_mac_rdata,
   input  wire eth_rmii_pkg::byte_beat_t i_cpu,
   input  wire  [AW-1:0]                i_cpu_raddr,
   output logic [7:0]                   o_cpu_rdata
);

   logic [7:0] mem [2**AW];

   always_ff @(posedge clk_rmii)
   begin
      if (i_cpu.wr)
         mem[i_cpu.addr] <= i_cpu.data;
      if (i_mac_wr.wr)
         mem[i_mac_wr.addr] <= i_mac_wr.data;
      o_mac_rdata <= mem[i_mac_raddr];
      o_cpu_rdata <= mem[i_cpu_raddr];
   end

endmodule

`default_nettype wire

// File: verilog/eth_tx_framer.sv
// RMII transmit framer; i_len must be 1 to 252 and stay stable while o_busy is high
`timescale 1ns/1ns
`default_nettype none
`include "eth_rmii_params.svh"

module eth_tx_framer
(
   input  wire         clk_rmii,
   input  wire         rstn,
   input  wire         i_start,
   input  wire  [8:0]  i_len,
   output logic        o_busy,
   output logic [7:0]  o_buf_raddr,
   input  wire  [7:0]  i_buf_rdata,
   output logic [1:0]  o_txd,
   output logic        o_tx_en
);
   import eth_rmii_pkg::*;

   tx_state_e   state;
   tx_state_e   nxt_state;
   logic [1:0]  dib;               // Dibit now on o_txd
   logic [8:0]  cnt;               // Byte in phase, or gap cycle
   logic [8:0]  nxt_cnt;
   logic [7:0]  byte_q;
   logic [7:0]  nxt_byte;
   logic [31:0] crc;
   logic        crc_en;

   assign o_busy      = (state != TX_IDLE);
   assign o_buf_raddr = (state == TX_DATA) ? cnt[7:0] + 8'd1 : 8'd0;   // Stable over the byte
   assign crc_en      = (dib == 2'd3) && (nxt_state == TX_DATA || nxt_state == TX_PAD);

   // Byte that follows the current one
   always_comb
   begin
      nxt_state = state;
      nxt_cnt   = cnt + 9'd1;
      nxt_byte  = 8'h00;
      case (state)
         TX_PRE:
         begin
            if (cnt == 9'd7)
            begin
               nxt_state = TX_DATA;
               nxt_cnt   = 9'd0;
               nxt_byte  = i_buf_rdata;
            end
            else
               nxt_byte = (cnt == 9'd6) ? 8'hD5 : 8'h55;   // SFD ends the preamble
         end
         TX_DATA:
         begin
            if (cnt != i_len - 9'd1)
               nxt_byte = i_buf_rdata;
            else if (i_len < 9'(`MIN_PAYLOAD))
               nxt_state = TX_PAD;                         // Count runs on from the payload
            else
            begin
               nxt_state = TX_FCS;
               nxt_cnt   = 9'd0;
               nxt_byte  = ~crc[7:0];
            end
         end
         TX_PAD:
         begin
            if (cnt == 9'(`MIN_PAYLOAD - 1))
            begin
               nxt_state = TX_FCS;
               nxt_cnt   = 9'd0;
               nxt_byte  = ~crc[7:0];
            end
         end
         TX_FCS:
         begin
            if (cnt == 9'd3)
            begin
               nxt_state = TX_GAP;
               nxt_cnt   = 9'd0;
            end
            else
               nxt_byte = ~crc[8*(cnt[1:0]+2'd1) +: 8];   // Low byte first
         end
         default:
            nxt_state = state;
      endcase
   end

   always_ff @(posedge clk_rmii)
   begin
      if (!rstn)
      begin
         state   <= TX_IDLE;
         dib     <= 2'd0;
         cnt     <= 9'd0;
         byte_q  <= 8'h00;
         o_txd   <= 2'b00;
         o_tx_en <= 1'b0;
      end
      else
      begin
         case (state)
            TX_IDLE:
            begin
               if (i_start)
               begin
                  state   <= TX_PRE;
                  dib     <= 2'd0;
                  cnt     <= 9'd0;
                  byte_q  <= 8'h55;
                  o_txd   <= 2'b01;
                  o_tx_en <= 1'b1;
               end
            end
            TX_GAP:
            begin
               cnt <= cnt + 9'd1;
               if (cnt == 9'(`IFG_CYCLES - 1))
                  state <= TX_IDLE;
            end
            default:
            begin
               dib <= dib + 2'd1;
               if (dib == 2'd3)
               begin
                  state   <= nxt_state;
                  cnt     <= nxt_cnt;
                  byte_q  <= nxt_byte;
                  o_txd   <= nxt_byte[1:0];
                  o_tx_en <= (nxt_state != TX_GAP);
               end
               else
                  o_txd <= byte_q[2*(dib+2'd1) +: 2];
            end
         endcase
      end
   end

   eth_crc32 crc_i
   (
      .clk_rmii (clk_rmii),
      .rstn     (rstn),
      .i_init   (state == TX_IDLE),
      .i_en     (crc_en),
      .i_data   (nxt_byte),
      .o_crc    (crc)
   );

endmodule

`default_nettype wire

// File: verilog/eth_rx_deframer.sv
// RMII receive deframer; no rx_er, no multicast, frames over 256 bytes and held-status frames dropped
`timescale 1ns/1ns
`default_nettype none
`include "eth_rmii_params.svh"

module eth_rx_deframer
(
   input  wire                           clk_rmii,
   input  wire                           rstn,
   input  wire  [1:0]                    i_rxd,
   input  wire                           i_crs_dv,
   input  wire  [47:0]                   i_mac,
   input  wire                           i_promisc,
   output eth_rmii_pkg::byte_beat_t      o_buf_wr,
   output eth_rmii_pkg::rx_status_t      o_status,
   output logic                          o_done,
   input  wire                           i_release
);
   import eth_rmii_pkg::*;

   rx_state_e   state;
   logic [7:0]  sh;                // Newest dibit enters at the top
   logic [7:0]  sh_nxt;
   logic [1:0]  dib;
   logic [8:0]  cnt;               // Bytes stored so far
   logic        own_ok;
   logic        bc_ok;
   logic        own_nxt;
   logic        bc_nxt;
   logic        keep;
   logic        byte_done;
   logic [31:0] crc;
   logic [31:0] crc_rev;

   assign sh_nxt    = {i_rxd, sh[7:2]};
   assign byte_done = (state == RX_DATA) && i_crs_dv && (dib == 2'd3);
   assign own_nxt   = (cnt == 9'd0 || own_ok) && (sh_nxt == i_mac[47 - 8*cnt[2:0] -: 8]);
   assign bc_nxt    = (cnt == 9'd0 || bc_ok) && (sh_nxt == 8'hFF);
   assign keep      = !cnt[8] && (i_promisc || cnt >= 9'd6 || own_nxt || bc_nxt);
   assign crc_rev   = {<<{crc}};   // Register is reflected

   always_ff @(posedge clk_rmii)
   begin
      sh <= sh_nxt;
      if (!rstn)
      begin
         state    <= RX_IDLE;
         dib      <= 2'd0;
         cnt      <= 9'd0;
         own_ok   <= 1'b0;
         bc_ok    <= 1'b0;
         o_buf_wr <= '0;
         o_status <= '0;
         o_done   <= 1'b0;
      end
      else
      begin
         o_buf_wr.wr <= 1'b0;
         o_done      <= 1'b0;
         if (i_release)
            o_status.valid <= 1'b0;
         case (state)
            RX_IDLE:
            begin
               if (i_crs_dv)
                  state <= o_status.valid ? RX_DROP : RX_PRE;   // Held status blocks the frame
            end
            RX_PRE:
            begin
               if (!i_crs_dv)
                  state <= RX_IDLE;
               else if (sh_nxt == 8'hD5)
               begin
                  state <= RX_DATA;
                  dib   <= 2'd0;
                  cnt   <= 9'd0;
               end
            end
            RX_DATA:
            begin
               if (!i_crs_dv)
                  state <= RX_DONE;
               else
               begin
                  dib <= dib + 2'd1;
                  if (dib == 2'd3 && keep)
                  begin
                     o_buf_wr <= '{wr: 1'b1, addr: cnt[7:0], data: sh_nxt};
                     cnt      <= cnt + 9'd1;
                     if (cnt < 9'd6)
                     begin
                        own_ok <= own_nxt;
                        bc_ok  <= bc_nxt;
                     end
                  end
                  else if (dib == 2'd3)
                     state <= RX_DROP;
               end
            end
            RX_DONE:
            begin
               o_status <= '{valid: 1'b1, fcs_bad: (crc_rev != `CRC_RESIDUE), len: cnt};
               o_done   <= 1'b1;
               state    <= RX_IDLE;
            end
            default:
            begin
               if (!i_crs_dv)
                  state <= RX_IDLE;
            end
         endcase
      end
   end

   eth_crc32 crc_i
   (
      .clk_rmii (clk_rmii),
      .rstn     (rstn),
      .i_init   (state == RX_PRE),
      .i_en     (byte_done),
      .i_data   (sh_nxt),
      .o_crc    (crc)
   );

endmodule

`default_nettype wire

// File: verilog/eth_regs.sv
// CPU window on clk_rmii; read data follows one cycle later, TX_LEN writes while busy are ignored
`timescale 1ns/1ns
`default_nettype none
`include "eth_rmii_params.svh"

module eth_regs
(
   input  wire                           clk_rmii,
   input  wire                           rstn,
   input  wire eth_rmii_pkg::bus_req_t   i_bus,
   output logic [31:0]                   o_rdata,
   output logic                          o_irq,
   output logic [47:0]                   o_mac,
   output logic                          o_promisc,
   output logic                          o_loopback,
   output logic                          o_tx_start,
   output logic [8:0]                    o_tx_len,
   input  wire                           i_tx_busy,
   input  wire eth_rmii_pkg::rx_status_t i_rx_status,
   output logic                          o_rx_release,
   output eth_rmii_pkg::byte_beat_t      o_txbuf_wr,
   output eth_rmii_pkg::byte_beat_t      o_rxbuf_wr,
   output logic [7:0]                    o_buf_raddr,
   input  wire  [7:0]                    i_txbuf_rdata,
   input  wire  [7:0]                    i_rxbuf_rdata
);
   import eth_rmii_pkg::*;

   reg_addr_e   offset;
   logic        buf_wr;
   logic        reg_wr;
   logic        irq_en;
   logic        rd_sel;
   logic [1:0]  rd_region;
   logic [31:0] rd_reg;

   assign offset       = reg_addr_e'(i_bus.addr[1:0]);
   assign buf_wr       = i_bus.sel && i_bus.we;
   assign reg_wr       = buf_wr && (i_bus.addr[11:10] == 2'b01);
   assign o_rx_release = reg_wr && (offset == REG_RX_STAT);
   assign o_buf_raddr  = i_bus.addr[7:0];
   assign o_rxbuf_wr   = '{wr: buf_wr && (i_bus.addr[11:10] == 2'b00),
                           addr: i_bus.addr[7:0], data: i_bus.wdata[7:0]};
   assign o_txbuf_wr   = '{wr: buf_wr && (i_bus.addr[11:10] == 2'b10),
                           addr: i_bus.addr[7:0], data: i_bus.wdata[7:0]};

   always_ff @(posedge clk_rmii)
   begin
      if (!rstn)
      begin
         o_mac      <= `MAC_RESET;
         o_promisc  <= 1'b0;
         o_loopback <= 1'b0;
         irq_en     <= 1'b0;
         o_tx_start <= 1'b0;
         o_tx_len   <= 9'd0;
         o_irq      <= 1'b0;
         rd_sel     <= 1'b0;
         rd_region  <= 2'b00;
      end
      else
      begin
         o_tx_start <= 1'b0;
         o_irq      <= i_rx_status.valid && irq_en && !o_rx_release;   // Drops with valid
         rd_sel     <= i_bus.sel && !i_bus.we;
         rd_region  <= i_bus.addr[11:10];
         if (reg_wr)
         begin
            case (offset)
               REG_MAC_LO:
                  o_mac[31:0] <= i_bus.wdata;
               REG_MAC_HI:
                  {irq_en, o_loopback, o_promisc, o_mac[47:32]} <= i_bus.wdata[18:0];
               REG_TX_LEN:
               begin
                  if (!i_tx_busy && !o_tx_start)
                  begin
                     o_tx_len   <= i_bus.wdata[8:0];
                     o_tx_start <= 1'b1;
                  end
               end
               default:
                  o_tx_start <= 1'b0;   // RX_STAT write only releases
            endcase
         end
      end
   end

   always_ff @(posedge clk_rmii)
   begin
      case (offset)
         REG_MAC_LO:  rd_reg <= o_mac[31:0];
         REG_MAC_HI:  rd_reg <= {13'd0, irq_en, o_loopback, o_promisc, o_mac[47:32]};
         REG_TX_LEN:  rd_reg <= {i_tx_busy, 22'd0, o_tx_len};
         REG_RX_STAT: rd_reg <= {i_rx_status.valid, i_rx_status.fcs_bad, 21'd0, i_rx_status.len};
      endcase
   end

   // Buffer data arrives with the same one-cycle delay as rd_reg
   always_comb
   begin
      case (rd_region)
         2'b00:   o_rdata = {24'd0, i_rxbuf_rdata};
         2'b01:   o_rdata = rd_reg;
         2'b10:   o_rdata = {24'd0, i_txbuf_rdata};
         default: o_rdata = 32'd0;
      endcase
      if (!rd_sel)
         o_rdata = 32'd0;
   end

endmodule

`default_nettype wire

// File: verilog/eth_rmii_top.sv
// RMII framing top on one clock; no MDIO, PHY reset or rx_er, and TX pins stay live in loopback
`timescale 1ns/1ns
`default_nettype none

module eth_rmii_top
(
   input  wire                         clk_rmii,
   input  wire                         rstn,
   input  wire eth_rmii_pkg::bus_req_t i_bus,
   output logic [31:0]                 o_rdata,
   output logic                        o_irq,
   input  wire  [1:0]                  i_rxd,
   input  wire                         i_crs_dv,
   output logic [1:0]                  o_txd,
   output logic                        o_tx_en
);
   import eth_rmii_pkg::*;

   logic [47:0] mac;
   logic        promisc;
   logic        loopback;
   logic        tx_start;
   logic [8:0]  tx_len;
   logic        tx_busy;
   logic [7:0]  tx_raddr;
   logic [7:0]  tx_rdata;
   logic        rx_release;
   rx_status_t  rx_status;
   byte_beat_t  rx_wr;
   byte_beat_t  txbuf_wr;
   byte_beat_t  rxbuf_wr;
   logic [7:0]  buf_raddr;
   logic [7:0]  txbuf_rdata;
   logic [7:0]  rxbuf_rdata;
   logic [1:0]  rx_rxd;
   logic        rx_crs;

   assign rx_rxd = loopback ? o_txd : i_rxd;
   assign rx_crs = loopback ? o_tx_en : i_crs_dv;

   eth_regs regs_i
   (
      .clk_rmii      (clk_rmii),
      .rstn          (rstn),
      .i_bus         (i_bus),
      .o_rdata       (o_rdata),
      .o_irq         (o_irq),
      .o_mac         (mac),
      .o_promisc     (promisc),
      .o_loopback    (loopback),
      .o_tx_start    (tx_start),
      .o_tx_len      (tx_len),
      .i_tx_busy     (tx_busy),
      .i_rx_status   (rx_status),
      .o_rx_release  (rx_release),
      .o_txbuf_wr    (txbuf_wr),
      .o_rxbuf_wr    (rxbuf_wr),
      .o_buf_raddr   (buf_raddr),
      .i_txbuf_rdata (txbuf_rdata),
      .i_rxbuf_rdata (rxbuf_rdata)
   );

   eth_tx_framer tx_i
   (
      .clk_rmii    (clk_rmii),
      .rstn        (rstn),
      .i_start     (tx_start),
      .i_len       (tx_len),
      .o_busy      (tx_busy),
      .o_buf_raddr (tx_raddr),
      .i_buf_rdata (tx_rdata),
      .o_txd       (o_txd),
      .o_tx_en     (o_tx_en)
   );

   eth_rx_deframer rx_i
   (
      .clk_rmii  (clk_rmii),
      .rstn      (rstn),
      .i_rxd     (rx_rxd),
      .i_crs_dv  (rx_crs),
      .i_mac     (mac),
      .i_promisc (promisc),
      .o_buf_wr  (rx_wr),
      .o_status  (rx_status),
      .o_done    (),
      .i_release (rx_release)
   );

   eth_frame_buf tx_buf_i
   (
      .clk_rmii    (clk_rmii),
      .i_mac_wr    ('0),
      .i_mac_raddr (tx_raddr),
      .o_mac_rdata (tx_rdata),
      .i_cpu       (txbuf_wr),
      .i_cpu_raddr (buf_raddr),
      .o_cpu_rdata (txbuf_rdata)
   );

   eth_frame_buf rx_buf_i
   (
      .clk_rmii    (clk_rmii),
      .i_mac_wr    (rx_wr),
      .i_mac_raddr (8'd0),
      .o_mac_rdata (),
      .i_cpu       (rxbuf_wr),
      .i_cpu_raddr (buf_raddr),
      .o_cpu_rdata (rxbuf_rdata)
   );

endmodule

`default_nettype wire

// File: tb/eth_rmii_assertions.sv
// Bound into eth_rmii_top; checks are sampled on clk_rmii and rely on the top's rx_status and rx_wr nets
`timescale 1ns/1ns
`default_nettype none

module eth_rmii_assertions
(
   input wire                           clk_rmii,
   input wire                           rstn,
   input wire                           i_tx_en,
   input wire                           i_irq,
   input wire eth_rmii_pkg::rx_status_t i_rx_status,
   input wire eth_rmii_pkg::byte_beat_t i_rx_wr
);

   int n_fail = 0;

   quiet_after_reset: assert property (@(posedge clk_rmii)
      $rose(rstn) |-> !i_tx_en && !i_irq)
      else
      begin
         n_fail++;
         $error("tx_en or irq high in the cycle after reset");
      end

   irq_needs_valid: assert property (@(posedge clk_rmii) disable iff (!rstn)
      i_irq |-> i_rx_status.valid)
      else
      begin
         n_fail++;
         $error("irq high without receive status valid");
      end

   // Held status must block the deframer from touching the buffer
   no_write_while_held: assert property (@(posedge clk_rmii) disable iff (!rstn)
      i_rx_status.valid |-> !i_rx_wr.wr)
      else
      begin
         n_fail++;
         $error("receive buffer written while status is held");
      end

endmodule

bind eth_rmii_top eth_rmii_assertions assertions_i
(
   .clk_rmii    (clk_rmii),
   .rstn        (rstn),
   .i_tx_en     (o_tx_en),
   .i_irq       (o_irq),
   .i_rx_status (rx_status),
   .i_rx_wr     (rx_wr)
);

`default_nettype wire

// File: tb/eth_rmii_tb.sv
// Testbench for eth_rmii_top; needs verilog/ on the include path and runs in loopback and external modes
`timescale 1ns/1ns
`default_nettype none
`include "eth_rmii_params.svh"

module eth_rmii_tb;
   import eth_rmii_pkg::*;

   localparam logic [1:0]  DEST_OWN   = 2'd0;
   localparam logic [1:0]  DEST_BCAST = 2'd1;
   localparam logic [1:0]  DEST_OTHER = 2'd2;
   localparam logic [47:0] RESET_MAC  = `MAC_RESET;
   localparam logic [47:0] OWN_MAC    = 48'h02_12_34_56_78_9A;
   localparam logic [47:0] OTHER_MAC  = 48'h0A_00_00_00_00_05;
   localparam int          TIMEOUT    = 2000;
   localparam int          N_ROWS     = 6;

   typedef struct packed {
      logic [1:0] dest;
      logic [8:0] len;
      logic       promisc;
      logic       loopback;
      logic       corrupt;             // Flip one FCS bit, external frames only
      logic       accept;
   } row_t;

   localparam row_t ROWS [N_ROWS] = '{
      '{DEST_OWN,   9'd20,  1'b0, 1'b1, 1'b0, 1'b1},
      '{DEST_BCAST, 9'd200, 1'b0, 1'b1, 1'b0, 1'b1},
      '{DEST_OTHER, 9'd30,  1'b0, 1'b1, 1'b0, 1'b0},
      '{DEST_OTHER, 9'd30,  1'b1, 1'b1, 1'b0, 1'b1},
      '{DEST_OWN,   9'd40,  1'b0, 1'b0, 1'b1, 1'b1},
      '{DEST_OWN,   9'd252, 1'b0, 1'b1, 1'b0, 1'b1}
   };

   logic        clk_rmii;
   logic        rstn;
   bus_req_t    bus;
   logic [31:0] rdata;
   logic        irq;
   logic [1:0]  rxd;
   logic        crs_dv;
   logic [1:0]  txd;
   logic        tx_en;

   integer      seed;
   int          n_checks;
   int          n_errors;
   logic        timed_out;
   logic [7:0]  frame [256];           // Bytes as they should land in the receive buffer
   int          frame_len;

   eth_rmii_top dut_i
   (
      .clk_rmii (clk_rmii),
      .rstn     (rstn),
      .i_bus    (bus),
      .o_rdata  (rdata),
      .o_irq    (irq),
      .i_rxd    (rxd),
      .i_crs_dv (crs_dv),
      .o_txd    (txd),
      .o_tx_en  (tx_en)
   );

   always #50 clk_rmii = ~clk_rmii;

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      n_errors++;
      timed_out = 1'b1;
      $display("timeout at %0t ns while waiting for %s", $time, what);
   endtask

   task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk_rmii);
      bus <= '{sel: 1'b1, we: 1'b1, addr: addr, wdata: data};
      @(posedge clk_rmii);
      bus <= '0;
   endtask

   task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
      @(posedge clk_rmii);
      bus <= '{sel: 1'b1, we: 1'b0, addr: addr, wdata: 32'd0};
      @(posedge clk_rmii);
      bus <= '0;
      @(negedge clk_rmii);
      data = rdata;
   endtask

   // Ethernet CRC-32, reflected, over frame[0 .. n-1]; returns the complement as sent
   function automatic logic [31:0] crc32(input int n);
      logic [31:0] c;
      c = `CRC_INIT;
      for (int i = 0; i < n; i++)
      begin
         c = c ^ {24'd0, frame[i]};
         for (int b = 0; b < 8; b++)
            c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
      end
      return ~c;
   endfunction

   // Byte i on the wire, preamble and SFD first
   function automatic logic [7:0] wire_byte(input int i);
      if (i < 7)
         return 8'h55;
      else if (i == 7)
         return 8'hD5;
      else
         return frame[i - 8];
   endfunction

   task automatic build_frame(input row_t row);
      logic [47:0] dest;
      logic [31:0] fcs;
      int          body;
      if (row.dest == DEST_OWN)
         dest = OWN_MAC;
      else if (row.dest == DEST_BCAST)
         dest = 48'hFFFF_FFFF_FFFF;
      else
         dest = OTHER_MAC;
      body = (row.len < `MIN_PAYLOAD) ? `MIN_PAYLOAD : int'(row.len);
      for (int i = 0; i < body; i++)
      begin
         if (i < 6)
            frame[i] = dest[47 - 8*i -: 8];   // First byte on the wire
         else if (i < row.len)
            frame[i] = 8'($random(seed));
         else
            frame[i] = 8'h00;
      end
      fcs = crc32(body);
      for (int i = 0; i < 4; i++)
         frame[body + i] = fcs[8*i +: 8];     // Low byte first
      if (row.corrupt)
         frame[body + 1] = frame[body + 1] ^ 8'h10;
      frame_len = body + 4;
   endtask

   task automatic send_loopback(input row_t row);
      logic [31:0] rd;
      logic [7:0]  b;
      int          wait_n;
      int          high_n;
      for (int i = 0; i < row.len; i++)
         bus_write(12'h800 + 12'(i), {24'd0, frame[i]});
      bus_write(12'h402, {23'd0, row.len});
      wait_n = 0;
      do
      begin
         @(negedge clk_rmii);
         wait_n++;
      end
      while (!tx_en && wait_n < TIMEOUT);
      if (!tx_en)
         report_timeout("tx_en to rise");
      else
      begin
         high_n = 0;
         while (tx_en && high_n < TIMEOUT)
         begin
            if (high_n < 4 * (8 + frame_len))
            begin
               b = wire_byte(high_n / 4);
               check("txd dibit", txd, b[2*(high_n % 4) +: 2]);
            end
            high_n++;
            @(negedge clk_rmii);
         end
         check("tx_en high cycles", high_n, 32 + 4 * (frame_len - 4 + 4));
      end
      wait_n = 0;
      rd = 32'hFFFF_FFFF;
      while (rd[31] && wait_n < TIMEOUT)
      begin
         bus_read(12'h402, rd);
         wait_n++;
      end
      if (rd[31])
         report_timeout("transmit busy to clear");
      check("tx length readback", rd[8:0], row.len);
   endtask

   task automatic send_external();
      logic [7:0] b;
      for (int i = 0; i < 8 + frame_len; i++)
      begin
         b = wire_byte(i);
         for (int d = 0; d < 4; d++)
         begin
            @(posedge clk_rmii);
            rxd    <= b[2*d +: 2];
            crs_dv <= 1'b1;
         end
      end
      @(posedge clk_rmii);
      rxd    <= 2'b00;
      crs_dv <= 1'b0;
   endtask

   task automatic check_receive(input row_t row);
      logic [31:0] rd;
      int          n;
      n  = 0;
      rd = 32'd0;
      while (!rd[31] && n < 10)             // A dropped frame never sets valid
      begin
         bus_read(12'h403, rd);
         n++;
      end
      check("rx valid", rd[31], row.accept);
      if (row.accept && rd[31])
      begin
         check("rx fcs_bad", rd[30], row.corrupt);
         check("rx length", rd[8:0], frame_len);
         @(negedge clk_rmii);
         check("irq with status", irq, 1'b1);
         for (int i = 0; i < frame_len; i++)
         begin
            bus_read(12'(i), rd);
            check("rx buffer byte", rd, {24'd0, frame[i]});
         end
         if (!row.loopback)
         begin
            frame[6] = ~frame[6];            // Second frame arrives while status is held
            send_external();
            bus_read(12'd6, rd);
            check("rx buffer byte while held", rd, {24'd0, ~frame[6]});
         end
      end
      bus_write(12'h403, 32'd0);
      @(negedge clk_rmii);
      check("irq after release", irq, 1'b0);
      bus_read(12'h403, rd);
      check("rx valid after release", rd[31], 1'b0);
   endtask

   initial
   begin
      logic [31:0] rd;
      row_t        row;
      seed      = 32'h766f_6611;
      n_checks  = 0;
      n_errors  = 0;
      timed_out = 1'b0;
      clk_rmii  = 1'b0;
      rstn      = 1'b0;
      bus       = '0;
      rxd       = 2'b00;
      crs_dv    = 1'b0;
      repeat (10) @(posedge clk_rmii);
      rstn <= 1'b1;

      bus_read(12'h400, rd);
      check("mac lo after reset", rd, RESET_MAC[31:0]);
      bus_read(12'h401, rd);
      check("mac hi after reset", rd, {16'd0, RESET_MAC[47:32]});
      bus_write(12'h400, 32'hA5A5_5A5A);
      bus_write(12'h401, 32'hFFFF_C3C3);      // Bits above 18 do not exist
      bus_read(12'h400, rd);
      check("mac lo readback", rd, 32'hA5A5_5A5A);
      bus_read(12'h401, rd);
      check("mac hi and control readback", rd, 32'h0007_C3C3);
      bus_write(12'h400, OWN_MAC[31:0]);

      for (int r = 0; r < N_ROWS && !timed_out; r++)
      begin
         row = ROWS[r];
         bus_write(12'h401, {13'd0, 1'b1, row.loopback, row.promisc, OWN_MAC[47:32]});
         build_frame(row);
         if (row.loopback)
            send_loopback(row);
         else
            send_external();
         check_receive(row);
      end

      n_errors = n_errors + dut_i.assertions_i.n_fail;
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/eth_rmii_pkg.sv
verilog/eth_crc32.sv
verilog/eth_frame_buf.sv
verilog/eth_tx_framer.sv
verilog/eth_rx_deframer.sv
verilog/eth_regs.sv
verilog/eth_rmii_top.sv
tb/eth_rmii_assertions.sv
tb/eth_rmii_tb.sv

// File: Bender.yml
package:
  name: eth_rmii

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/eth_rmii_pkg.sv
      - verilog/eth_crc32.sv
      - verilog/eth_frame_buf.sv
      - verilog/eth_tx_framer.sv
      - verilog/eth_rx_deframer.sv
      - verilog/eth_regs.sv
      - verilog/eth_rmii_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/eth_rmii_assertions.sv
      - tb/eth_rmii_tb.sv
